//--- logic/rob_pkg.sv
////////////////////////////////////////////////////////////////////////////
// reorder buffer shared definitions
// sizes, tags and the packet structs passed between the ROB blocks
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package rob_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////////////

    // entries in the circular buffer
    localparam int rob_depth = 8;
    // tag is the buffer index
    localparam int tag_width = 3;
    // counts must reach rob_depth itself
    localparam int count_width = 4;
    // architectural register index
    localparam int arch_reg_width = 5;
    // result and pc width
    localparam int data_width = 32;

    ////////////////////////////////////////////////////////////////////////////
    // basic types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [tag_width-1:0] rob_tag_t;
    typedef logic [count_width-1:0] rob_count_t;

    // destination record, stored at dispatch
    typedef struct packed {
        logic has_dest;
        logic [arch_reg_width-1:0] dest_reg;
        logic [data_width-1:0] pc;
    } dispatch_rec_t;

    // result payload, stored on completion
    typedef logic [data_width-1:0] result_t;

    ////////////////////////////////////////////////////////////////////////////
    // packets
    ////////////////////////////////////////////////////////////////////////////

    // in-order dispatch from the front end
    typedef struct packed {
        logic valid;
        dispatch_rec_t rec;
    } dispatch_t;

    // common data bus broadcast
    typedef struct packed {
        logic valid;
        rob_tag_t tag;
        result_t value;
    } cdb_t;

    // tag is the oldest entry to throw away
    typedef struct packed {
        logic valid;
        rob_tag_t tag;
    } squash_t;

    // one retired instruction per cycle
    typedef struct packed {
        logic valid;
        rob_tag_t tag;
        dispatch_rec_t rec;
        result_t value;
    } retire_t;

endpackage

`default_nettype wire

//--- logic/rob_entry_array.sv
////////////////////////////////////////////////////////////////////////////
// ROB entry storage
// one write port at the edge, one combinational read port
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rob_entry_array
    import rob_pkg::*;
#(
    // payload held per entry
    parameter type payload_t = result_t
) (
    input  logic     clock,
    input  logic     write,
    input  rob_tag_t write_index,
    input  payload_t write_data,
    input  rob_tag_t read_index,
    output payload_t read_data
);

    ////////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////////

    // contents only, entry validity lives in the control block
    payload_t entries [rob_depth];

    // write lands on the clock edge
    always_ff @(posedge clock) begin
        if (write) begin
            entries[write_index] <= write_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read
    ////////////////////////////////////////////////////////////////////////////

    // asynchronous read, follows the index within the cycle
    // a same-cycle write shows up only after the edge
    assign read_data = entries[read_index];

endmodule

`default_nettype wire

//--- logic/rob_control.sv
////////////////////////////////////////////////////////////////////////////
// ROB control
// pointers, occupancy, per-entry state, squash, credits and retire packet
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rob_control
    import rob_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  dispatch_t     dispatch,
    input  cdb_t          cdb,
    input  squash_t       squash,
    input  dispatch_rec_t head_rec,
    input  result_t       head_value,
    output rob_tag_t      dispatch_tag,
    output rob_tag_t      head_tag,
    output logic          rec_write,
    output logic          result_write,
    output retire_t       retire,
    output rob_count_t    credit_return
);

    ////////////////////////////////////////////////////////////////////////////
    // state
    ////////////////////////////////////////////////////////////////////////////

    // oldest entry, next free entry
    rob_tag_t head;
    rob_tag_t tail;
    // live entries, 0 to rob_depth
    rob_count_t occupancy;
    // per-entry flags
    logic [rob_depth-1:0] valid;
    logic [rob_depth-1:0] complete;

    // next-state values
    rob_tag_t head_next;
    rob_tag_t tail_next;
    rob_count_t occupancy_next;
    logic [rob_depth-1:0] valid_next;
    logic [rob_depth-1:0] complete_next;
    rob_count_t credit_next;

    // squash bookkeeping
    logic squash_hit;
    rob_tag_t squash_offset;
    rob_count_t squash_freed;
    logic [rob_depth-1:0] discard;
    logic [rob_depth-1:0] valid_kept;

    // per-cycle events
    logic cdb_take;
    logic retire_fire;

    ////////////////////////////////////////////////////////////////////////////
    // squash range
    ////////////////////////////////////////////////////////////////////////////

    // only a squash that points at a live entry changes state
    assign squash_hit = squash.valid && valid[squash.tag];

    // distance of the squash point from head
    assign squash_offset = squash.tag - head;
    // everything from the squash point to tail goes
    // works for a full buffer too, offset is then below occupancy
    assign squash_freed = occupancy - rob_count_t'(squash_offset);

    always_comb begin : discard_logic
        rob_tag_t entry_offset;
        discard = '0;
        for (int i = 0; i < rob_depth; i++) begin
            // age of entry i relative to head
            entry_offset = rob_tag_t'(i) - head;
            if (squash_hit && valid[i] && entry_offset >= squash_offset) begin
                discard[i] = 1'b1;
            end
        end
    end

    // live set once this cycle's squash is applied
    assign valid_kept = valid & ~discard;

    ////////////////////////////////////////////////////////////////////////////
    // events
    ////////////////////////////////////////////////////////////////////////////

    // squash wins over dispatch and retirement
    assign rec_write = dispatch.valid && !squash.valid;
    // late broadcasts to dead entries are dropped
    assign cdb_take = cdb.valid && valid_kept[cdb.tag];
    assign result_write = cdb_take;
    // head must already be complete, a cdb this cycle counts next cycle
    assign retire_fire = !squash.valid && valid[head] && complete[head];

    // the tag the next dispatch gets
    assign dispatch_tag = tail;
    assign head_tag = head;

    ////////////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        valid_next = valid_kept;
        complete_next = complete & ~discard;
        // completion first
        if (cdb_take) begin
            complete_next[cdb.tag] = 1'b1;
        end
        // retire frees the head slot
        if (retire_fire) begin
            valid_next[head] = 1'b0;
            complete_next[head] = 1'b0;
        end
        // dispatch last, may reuse the slot retired this cycle
        if (rec_write) begin
            valid_next[tail] = 1'b1;
            complete_next[tail] = 1'b0;
        end
    end

    always_comb begin
        head_next = head;
        tail_next = tail;
        occupancy_next = occupancy;
        credit_next = '0;
        if (squash_hit) begin
            // rewind, return exactly what was thrown away
            tail_next = squash.tag;
            occupancy_next = occupancy - squash_freed;
            credit_next = squash_freed;
        end else begin
            if (retire_fire) begin
                head_next = head + 1'b1;
                credit_next = rob_count_t'(1);
            end
            if (rec_write) begin
                tail_next = tail + 1'b1;
            end
            // net change from this cycle's dispatch and retirement
            if (rec_write && !retire_fire) begin
                occupancy_next = occupancy + 1'b1;
            end else if (retire_fire && !rec_write) begin
                occupancy_next = occupancy - 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            occupancy <= '0;
            valid <= '0;
            complete <= '0;
            credit_return <= '0;
            retire <= '0;
        end else begin
            head <= head_next;
            tail <= tail_next;
            occupancy <= occupancy_next;
            valid <= valid_next;
            complete <= complete_next;
            credit_return <= credit_next;
            // retire packet from the head slot as read this cycle
            retire.valid <= retire_fire;
            retire.tag <= head;
            retire.rec <= head_rec;
            retire.value <= head_value;
        end
    end

endmodule

`default_nettype wire

//--- logic/rob_top.sv
////////////////////////////////////////////////////////////////////////////
// reorder buffer top
// control block plus record and result arrays, read together at head
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rob_top
    import rob_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  dispatch_t  dispatch,
    input  cdb_t       cdb,
    input  squash_t    squash,
    output rob_tag_t   dispatch_tag,
    output retire_t    retire,
    output rob_count_t credit_return
);

    ////////////////////////////////////////////////////////////////////////////
    // internal wiring
    ////////////////////////////////////////////////////////////////////////////

    // shared read index for both arrays
    rob_tag_t head_tag;
    // write enables from control
    logic rec_write;
    logic result_write;
    // head slot contents
    dispatch_rec_t head_rec;
    result_t head_value;

    ////////////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////////////

    rob_control control (
        .clock         (clock),
        .reset         (reset),
        .dispatch      (dispatch),
        .cdb           (cdb),
        .squash        (squash),
        .head_rec      (head_rec),
        .head_value    (head_value),
        .dispatch_tag  (dispatch_tag),
        .head_tag      (head_tag),
        .rec_write     (rec_write),
        .result_write  (result_write),
        .retire        (retire),
        .credit_return (credit_return)
    );

    ////////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////////

    // dispatch records, written at tail
    rob_entry_array #(.payload_t(dispatch_rec_t)) record_array (
        .clock       (clock),
        .write       (rec_write),
        .write_index (dispatch_tag),
        .write_data  (dispatch.rec),
        .read_index  (head_tag),
        .read_data   (head_rec)
    );

    // results, written by cdb tag
    rob_entry_array #(.payload_t(result_t)) result_array (
        .clock       (clock),
        .write       (result_write),
        .write_index (cdb.tag),
        .write_data  (cdb.value),
        .read_index  (head_tag),
        .read_data   (head_value)
    );

endmodule

`default_nettype wire

//--- verification/rob_sva.sv
////////////////////////////////////////////////////////////////////////////
// ROB control assertions
// credit protocol, retire legality and known state out of reset
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rob_sva
    import rob_pkg::*;
(
    input logic                 clock,
    input logic                 reset,
    input dispatch_t            dispatch,
    input rob_tag_t             head,
    input rob_tag_t             tail,
    input rob_count_t           occupancy,
    input logic [rob_depth-1:0] valid,
    input logic [rob_depth-1:0] complete,
    input retire_t              retire,
    input rob_count_t           credit_return
);

    // dispatcher without credits must hold off
    no_dispatch_when_full: assert property (@(posedge clock) disable iff (reset)
        !(dispatch.valid && occupancy == rob_count_t'(rob_depth)))
        else $error("dispatch while all entries are in use");

    // never free more than was live
    credit_bounded: assert property (@(posedge clock) disable iff (reset)
        credit_return <= $past(occupancy))
        else $error("credit_return above previous occupancy");

    // head was live and complete the cycle before
    retire_legal: assert property (@(posedge clock) disable iff (reset)
        retire.valid |-> $past(valid[head] && complete[head]))
        else $error("retire without a complete head entry");

    known_state: assert property (@(posedge clock) disable iff (reset)
        !$isunknown({retire.valid, credit_return, head, tail, occupancy, valid, complete}))
        else $error("unknown value in ROB control state");

endmodule

bind rob_control rob_sva sva (
    .clock         (clock),
    .reset         (reset),
    .dispatch      (dispatch),
    .head          (head),
    .tail          (tail),
    .occupancy     (occupancy),
    .valid         (valid),
    .complete      (complete),
    .retire        (retire),
    .credit_return (credit_return)
);

`default_nettype wire

//--- verification/rob_tb.sv
////////////////////////////////////////////////////////////////////////////
// reorder buffer testbench
// credit-keeping dispatcher, random cdb and squash, cycle-level model
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rob_tb
    import rob_pkg::*;
();

    // run lengths
    localparam int steady_cycles = 300;
    localparam int mix_cycles = 1500;
    // roughly twice the cycles all tests need
    localparam int cycle_limit = 4000;

    // one outstanding instruction in the model
    typedef struct packed {
        rob_tag_t tag;
        dispatch_rec_t rec;
        logic done;
        result_t value;
    } entry_t;

    logic clock;
    logic reset;
    dispatch_t dispatch;
    cdb_t cdb;
    squash_t squash;
    rob_tag_t dispatch_tag;
    retire_t retire;
    rob_count_t credit_return;

    // stimulus for the coming edge
    dispatch_t next_dispatch;
    cdb_t next_cdb;
    squash_t next_squash;

    // model state, oldest entry first
    entry_t model_q[$];
    rob_tag_t model_tail;
    retire_t exp_retire;
    rob_count_t exp_credit;

    // dispatcher and tallies
    int credits;
    int dispatched;
    int credit_sum;
    int retire_count;
    int checks;
    int errors;
    int test_errors;
    int cycle_count;
    integer seed;

    rob_top DUT (
        .clock         (clock),
        .reset         (reset),
        .dispatch      (dispatch),
        .cdb           (cdb),
        .squash        (squash),
        .dispatch_tag  (dispatch_tag),
        .retire        (retire),
        .credit_return (credit_return)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // run guard
    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("** FAIL **");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // inputs as sampled on this edge, outputs expected after it
    task automatic model_step();
        entry_t e;
        int cut;
        exp_retire = '0;
        exp_credit = '0;
        if (squash.valid) begin
            // squash tag up to tail goes, no retirement
            cut = model_q.size();
            for (int i = 0; i < model_q.size(); i++) begin
                if (model_q[i].tag == squash.tag) begin
                    cut = i;
                end
            end
            exp_credit = rob_count_t'(model_q.size() - cut);
            // a tag that is no longer live leaves the tail alone
            if (cut < model_q.size()) begin
                model_tail = squash.tag;
            end
            while (model_q.size() > cut) begin
                void'(model_q.pop_back());
            end
        end else if (model_q.size() > 0 && model_q[0].done) begin
            // head complete before this edge
            e = model_q.pop_front();
            exp_retire = {1'b1, e.tag, e.rec, e.value};
            exp_credit = rob_count_t'(1);
        end
        // completion only for entries still alive
        if (cdb.valid) begin
            for (int i = 0; i < model_q.size(); i++) begin
                if (model_q[i].tag == cdb.tag) begin
                    e = model_q[i];
                    e.done = 1'b1;
                    e.value = cdb.value;
                    model_q[i] = e;
                end
            end
        end
        // new entry at tail, after the cdb lookup
        if (dispatch.valid && !squash.valid) begin
            e = '0;
            e.tag = model_tail;
            e.rec = dispatch.rec;
            model_q.push_back(e);
            model_tail = model_tail + rob_tag_t'(1);
        end
    endtask

    task automatic check_outputs();
        checks += 3;
        if (dispatch_tag !== model_tail) begin
            $display("[FAIL] dispatch_tag expected %h actual %h", model_tail, dispatch_tag);
            errors++;
        end
        if (credit_return !== exp_credit) begin
            $display("[FAIL] credit_return expected %h actual %h", exp_credit, credit_return);
            errors++;
        end
        if (retire.valid !== exp_retire.valid || (exp_retire.valid && retire !== exp_retire)) begin
            $display("[FAIL] retire expected %h actual %h", exp_retire, retire);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    // one clock: model, drive, then compare at the falling edge
    task automatic step();
        @(posedge clock);
        model_step();
        dispatch <= next_dispatch;
        cdb <= next_cdb;
        squash <= next_squash;
        if (next_dispatch.valid) begin
            credits--;
            dispatched++;
        end
        next_dispatch = '0;
        next_cdb = '0;
        next_squash = '0;
        @(negedge clock);
        check_outputs();
        // retirements as seen on the DUT port
        if (retire.valid === 1'b1) begin
            retire_count++;
        end
        credits += int'(credit_return);
        credit_sum += int'(credit_return);
    endtask

    task automatic set_dispatch();
        next_dispatch.valid = 1'b1;
        next_dispatch.rec.has_dest = 1'($random(seed));
        next_dispatch.rec.dest_reg = arch_reg_width'($random(seed));
        next_dispatch.rec.pc = $random(seed);
    endtask

    task automatic set_cdb(input rob_tag_t tag, input result_t value);
        next_cdb.valid = 1'b1;
        next_cdb.tag = tag;
        next_cdb.value = value;
    endtask

    // random incomplete entry, skipping the one already on the bus
    task automatic pick_cdb();
        rob_tag_t pool[$];
        foreach (model_q[i]) begin
            if (!model_q[i].done && !(cdb.valid && cdb.tag == model_q[i].tag)) begin
                pool.push_back(model_q[i].tag);
            end
        end
        if (pool.size() > 0) begin
            set_cdb(pool[$unsigned($random(seed)) % pool.size()], result_t'($random(seed)));
        end
    endtask

    // back to back while credits last, plus one cycle to land
    task automatic dispatch_run(input int n, output int sent);
        sent = 0;
        for (int i = 0; i < n; i++) begin
            if (credits > 0) begin
                set_dispatch();
                sent++;
            end
            step();
        end
        step();
    endtask

    // complete everything left until nothing is outstanding
    task automatic drain();
        do begin
            pick_cdb();
            step();
        end while (model_q.size() > 0);
    endtask

    task automatic check_conservation();
        checks += 2;
        if (credit_sum != dispatched) begin
            $display("[FAIL] credit_return sum expected %h actual %h", dispatched, credit_sum);
            errors++;
        end
        if (credits != rob_depth) begin
            $display("[FAIL] dispatcher credits expected %h actual %h", rob_depth, credits);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-20s %s, %0d errors", name,
                 (errors == test_errors) ? "ok" : "failed", errors - test_errors);
        test_errors = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int sent;
        int start;
        rob_tag_t base;
        entry_t victim;
        seed = 19;
        reset = 1'b1;
        dispatch = '0;
        cdb = '0;
        squash = '0;
        next_dispatch = '0;
        next_cdb = '0;
        next_squash = '0;
        model_tail = '0;
        exp_retire = '0;
        exp_credit = '0;
        credits = rob_depth;
        dispatched = 0;
        credit_sum = 0;
        retire_count = 0;
        checks = 0;
        errors = 0;
        test_errors = 0;
        repeat (16) @(posedge clock);
        reset <= 1'b0;

        // fill, stall on zero credits, drain, refill from tag 0
        dispatch_run(rob_depth + 2, sent);
        checks++;
        if (sent != rob_depth || credits != 0) begin
            $display("dispatcher did not stop at zero credits after %0d dispatches", sent);
            errors++;
        end
        for (int i = 0; i < rob_depth; i++) begin
            set_cdb(rob_tag_t'(i), result_t'($random(seed)));
            step();
        end
        drain();
        dispatch_run(rob_depth, sent);
        checks++;
        if (dispatch_tag !== rob_tag_t'(0)) begin
            $display("[FAIL] dispatch_tag expected %h actual %h", rob_tag_t'(0), dispatch_tag);
            errors++;
        end
        end_test("fill_and_wrap");

        // head completes last
        start = retire_count;
        for (int i = rob_depth - 1; i > 0; i--) begin
            set_cdb(rob_tag_t'(i), result_t'(32'hc0de_0000 + i));
            step();
        end
        checks++;
        if (retire_count != start) begin
            $display("retirement seen before the head entry completed");
            errors++;
        end
        set_cdb(rob_tag_t'(0), result_t'(32'hc0de_0000));
        step();
        drain();
        checks++;
        if (retire_count != start + rob_depth) begin
            $display("[FAIL] retire count expected %h actual %h", rob_depth, retire_count - start);
            errors++;
        end
        end_test("in_order_retire");

        // steady traffic without squash
        for (int n = 0; n < steady_cycles; n++) begin
            if (credits > 0 && ($random(seed) & 1)) begin
                set_dispatch();
            end
            if ($random(seed) & 1) begin
                pick_cdb();
            end
            step();
        end
        drain();
        check_conservation();
        end_test("credit_conservation");

        // six live, two complete, squash from the fourth
        base = model_tail;
        start = retire_count;
        dispatch_run(6, sent);
        set_cdb(rob_tag_t'(base + 1), result_t'($random(seed)));
        step();
        set_cdb(rob_tag_t'(base + 4), result_t'($random(seed)));
        step();
        next_squash.valid = 1'b1;
        next_squash.tag = rob_tag_t'(base + 3);
        step();
        // late broadcast to a discarded entry
        set_cdb(rob_tag_t'(base + 5), result_t'($random(seed)));
        step();
        checks += 2;
        if (credit_return !== rob_count_t'(3)) begin
            $display("[FAIL] credit_return expected %h actual %h", rob_count_t'(3), credit_return);
            errors++;
        end
        if (dispatch_tag !== rob_tag_t'(base + 3)) begin
            $display("[FAIL] dispatch_tag expected %h actual %h", rob_tag_t'(base + 3),
                     dispatch_tag);
            errors++;
        end
        dispatch_run(1, sent);
        for (int i = 0; i < 4; i++) begin
            if (i != 1) begin
                set_cdb(rob_tag_t'(base + i), result_t'($random(seed)));
                step();
            end
        end
        drain();
        checks++;
        if (retire_count - start != 4) begin
            $display("[FAIL] retire count expected %h actual %h", 4, retire_count - start);
            errors++;
        end
        end_test("squash");

        // random dispatch, completion and squash
        for (int n = 0; n < mix_cycles; n++) begin
            if (($unsigned($random(seed)) % 32) == 0 && model_q.size() > 0 && !squash.valid) begin
                // squash and dispatch never share an edge
                victim = model_q[$unsigned($random(seed)) % model_q.size()];
                next_squash.valid = 1'b1;
                next_squash.tag = victim.tag;
            end else if (credits > 0 && ($random(seed) & 1)) begin
                set_dispatch();
            end
            if ($random(seed) & 1) begin
                pick_cdb();
            end
            step();
        end
        drain();
        check_conservation();
        end_test("random_mix");

        $display("checks: %0d passed, %0d failed", checks - errors, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
logic/rob_pkg.sv
logic/rob_entry_array.sv
logic/rob_control.sv
logic/rob_top.sv
verification/rob_sva.sv
verification/rob_tb.sv
